// ==== common/mover_defs.svh ====
// Width, depth and APB register offset macros for the block mover.
`ifndef MOVER_DEFS_SVH
`define MOVER_DEFS_SVH

`define MOVER_ADDR_W    12      // DRAM word address.
`define MOVER_CNT_W     6       // Word count per transfer.
`define MOVER_ANCILL_W  25      // Section ancillary tag.
`define MOVER_WORD_W    16      // Line buffer word.
`define MOVER_DRAM_W    32      // DRAM data bus.
`define LSAB_DEPTH      64      // Words per section.
`define MOVER_APB_AW    8       // APB address.
`define MOVER_APB_DW    32      // APB data.

`define REG_ADDR        8'h00   // Start word address.
`define REG_COUNT       8'h04   // Word count.
`define REG_CTRL        8'h08   // Section, bank, issue.
`define REG_STATUS      8'h0C   // Working, done, flags, sent.
`define REG_ANCILL      8'h10   // Tag of the last transfer.

`endif

// ==== common/mover_pkg.sv ====
// Package with the block mover data types and engine state encoding.
`default_nettype none

`include "mover_defs.svh"

package mover_pkg;

	typedef logic [`MOVER_ADDR_W-1:0]   word_addr_t;  // DRAM word address.
	typedef logic [`MOVER_CNT_W-1:0]    word_cnt_t;   // Words in a transfer.
	typedef logic [1:0]                 section_t;    // LSAB section number.
	typedef logic [1:0]                 bank_sel_t;   // DRAM request code, 0 is idle.
	typedef logic [`MOVER_ANCILL_W-1:0] ancill_t;
	typedef logic [`MOVER_WORD_W-1:0]   lsab_word_t;
	typedef logic [`MOVER_DRAM_W-1:0]   dram_word_t;
	typedef logic [3:0]                 byte_en_t;    // One bit per DRAM byte lane.

	typedef enum logic [1:0]
	{
		IDLE,
		LOAD,
		MOVE,
		FINISH
	} engine_state_t;

endpackage

`default_nettype wire

// ==== common/lsab_if.sv ====
// Interface between the LSAB sections and the transfer engine.
`timescale 1ns/10ps
`default_nettype none

interface lsab_if;
	import mover_pkg::*;

	logic       rd;         // One word consumed this cycle.
	section_t   section;    // Section the engine reads from.
	logic       empty;
	lsab_word_t word;       // Head of the selected section.
	logic       irq_flag;
	ancill_t    ancill;

	modport lsab
	(
		input  rd,
		input  section,
		output empty,
		output word,
		output irq_flag,
		output ancill
	);

	modport engine
	(
		output rd,
		output section,
		input  empty,
		input  word,
		input  irq_flag,
		input  ancill
	);

endinterface

`default_nettype wire

// ==== common/done_if.sv ====
// Interface carrying the completion record from the engine to the status block.
`timescale 1ns/10ps
`default_nettype none

interface done_if;
	import mover_pkg::*;

	logic      done;        // One cycle, record valid.
	word_cnt_t sent;
	logic      abrupt;
	logic      irq_flag;
	ancill_t   ancill;

	modport source
	(
		output done, sent, abrupt, irq_flag, ancill
	);

	modport sink
	(
		input done, sent, abrupt, irq_flag, ancill
	);

endinterface

`default_nettype wire

// ==== lsab/lsab_sections.sv ====
// Four section line buffer FIFOs with per-section interrupt flag and tag.
`timescale 1ns/10ps
`default_nettype none

`include "mover_defs.svh"

module lsab_sections
(
	input  wire                        CLK,
	input  wire                        RST,
	input  wire                        wr,
	input  wire mover_pkg::section_t   wr_section,
	input  wire mover_pkg::lsab_word_t wr_data,
	input  wire                        mark,
	input  wire                        mark_int,
	input  wire mover_pkg::ancill_t    mark_ancill,
	output logic                       full,
	lsab_if.lsab                       rd_port
);
	import mover_pkg::*;

	localparam int NSEC  = 2 ** $bits(section_t);
	localparam int PTR_W = $clog2(`LSAB_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [PTR_W:0]   fill_t;  // One extra bit to tell full from empty.

	lsab_word_t      mem [NSEC][`LSAB_DEPTH];
	ptr_t            wr_ptr [NSEC];
	ptr_t            rd_ptr [NSEC];
	fill_t           fill [NSEC];
	ancill_t         tag [NSEC];
	logic [NSEC-1:0] int_flag;
	logic [NSEC-1:0] push_sel;
	logic [NSEC-1:0] pop_sel;
	logic            push;
	logic            pop;

	assign full  = (fill[wr_section] == fill_t'(`LSAB_DEPTH));
	assign push  = wr && !full;             // Writes to a full section are dropped.
	assign pop   = rd_port.rd && !rd_port.empty;

	// Selected section seen by the engine.
	assign rd_port.empty    = (fill[rd_port.section] == '0);
	assign rd_port.word     = mem[rd_port.section][rd_ptr[rd_port.section]];
	assign rd_port.irq_flag = int_flag[rd_port.section];
	assign rd_port.ancill   = tag[rd_port.section];

	always_comb
	begin
		push_sel = '0;
		pop_sel  = '0;
		push_sel[wr_section]      = push;
		pop_sel[rd_port.section]  = pop;
	end

	//////////////////////////////
	// Storage.
	always_ff @(posedge CLK)
	begin
		if (push)
			mem[wr_section][wr_ptr[wr_section]] <= wr_data;
		if (mark)
			tag[wr_section] <= mark_ancill;
	end

	//////////////////////////////
	// Pointers, fill levels, flags.
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			int_flag <= '0;
			for (int i = 0; i < NSEC; i++)
			begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				fill[i]   <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < NSEC; i++)
			begin
				if (push_sel[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1;   // Wraps at depth.
				if (pop_sel[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				if (push_sel[i] && !pop_sel[i])
					fill[i] <= fill[i] + 1'b1;
				else if (pop_sel[i] && !push_sel[i])
					fill[i] <= fill[i] - 1'b1;
				if (mark && (wr_section == section_t'(i)))
					int_flag[i] <= mark_int;
			end
		end
	end

endmodule

`default_nettype wire

// ==== mover/mover_regs.sv ====
// APB register file of the block mover with issue and clear pulses.
`timescale 1ns/10ps
`default_nettype none

`include "mover_defs.svh"

module mover_regs
(
	input  wire                        CLK,
	input  wire                        RST,
	input  wire [`MOVER_APB_AW-1:0]    paddr,
	input  wire                        psel,
	input  wire                        penable,
	input  wire                        pwrite,
	input  wire [`MOVER_APB_DW-1:0]    pwdata,
	output logic [`MOVER_APB_DW-1:0]   prdata,
	output logic                       pready,
	output logic                       pslverr,
	output mover_pkg::word_addr_t      start_addr,
	output mover_pkg::word_cnt_t       count,
	output mover_pkg::section_t        section,
	output mover_pkg::bank_sel_t       bank_sel,
	output logic                       issue,
	input  wire                        busy,
	input  wire                        done,
	input  wire                        irq_flag,
	input  wire                        abrupt,
	input  wire mover_pkg::word_cnt_t  sent,
	input  wire mover_pkg::ancill_t    ancill,
	output logic                       clear_done
);
	logic access;
	logic mapped;
	logic issue_req;
	logic wr_acc;

	assign access    = psel && penable;     // Access phase, never stretched.
	assign pready    = 1'b1;
	assign mapped    = (paddr == `REG_ADDR) || (paddr == `REG_COUNT) ||
		(paddr == `REG_CTRL) || (paddr == `REG_STATUS) || (paddr == `REG_ANCILL);
	assign issue_req = access && pwrite && (paddr == `REG_CTRL) && pwdata[4];
	assign pslverr   = access && (!mapped || (issue_req && busy));
	assign wr_acc    = access && pwrite && !pslverr;  // Rejected writes store nothing.

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			start_addr <= '0;
			count      <= '0;
			section    <= '0;
			bank_sel   <= '0;
			issue      <= 1'b0;
			clear_done <= 1'b0;
		end
		else
		begin
			issue      <= wr_acc && issue_req;
			clear_done <= wr_acc && (paddr == `REG_STATUS) && pwdata[1];
			if (wr_acc)
				case (paddr)
					`REG_ADDR:  start_addr <= pwdata[`MOVER_ADDR_W-1:0];
					`REG_COUNT: count      <= pwdata[`MOVER_CNT_W-1:0];
					`REG_CTRL:
					begin
						section  <= pwdata[1:0];
						bank_sel <= pwdata[3:2];
					end
					default: ;
				endcase
		end
	end

	// Read mux.
	always_comb
	begin
		prdata = '0;
		if (access && !pwrite)
			case (paddr)
				`REG_ADDR:   prdata[`MOVER_ADDR_W-1:0]   = start_addr;
				`REG_COUNT:  prdata[`MOVER_CNT_W-1:0]    = count;
				`REG_CTRL:   prdata[3:0]                 = {bank_sel, section};
				`REG_STATUS:
				begin
					prdata[3:0]               = {abrupt, irq_flag, done, busy};
					prdata[8 +: `MOVER_CNT_W] = sent;
				end
				`REG_ANCILL: prdata[`MOVER_ANCILL_W-1:0] = ancill;
				default:     prdata = '0;
			endcase
	end

endmodule

`default_nettype wire

// ==== mover/mover_engine.sv ====
// Transfer engine that pairs LSAB words into 32-bit DRAM write commands.
`timescale 1ns/10ps
`default_nettype none

module mover_engine
(
	input  wire                        CLK,
	input  wire                        RST,
	input  wire mover_pkg::word_addr_t start_addr,
	input  wire mover_pkg::word_cnt_t  count,
	input  wire mover_pkg::section_t   section,
	input  wire mover_pkg::bank_sel_t  bank_sel,
	input  wire                        issue,
	output logic                       busy,
	lsab_if.engine                     buff,
	done_if.source                     fin,
	output mover_pkg::bank_sel_t       dram_req,
	output mover_pkg::word_addr_t      dram_addr,
	output mover_pkg::dram_word_t      dram_data,
	output mover_pkg::byte_en_t        dram_be
);
	import mover_pkg::*;

	engine_state_t state;
	engine_state_t state_nxt;
	word_addr_t    cur_addr;    // Address of the next word read.
	word_cnt_t     left;        // Words still to move.
	word_cnt_t     job_cnt;
	section_t      job_section;
	bank_sel_t     job_bank;
	lsab_word_t    pend_word;   // Even word waiting for its odd partner.
	logic          have_pend;
	logic          take;
	logic          flush;

	assign take  = (state == MOVE) && (left != '0) && !buff.empty;
	assign flush = (state == FINISH) && have_pend;
	assign busy  = (state != IDLE);

	assign buff.rd      = take;
	assign buff.section = job_section;

	// Completion record, valid while in FINISH.
	assign fin.done     = (state == FINISH);
	assign fin.sent     = job_cnt - left;
	assign fin.abrupt   = (left != '0);
	assign fin.irq_flag = buff.irq_flag;
	assign fin.ancill   = buff.ancill;

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (issue)
					state_nxt = LOAD;
			LOAD:   state_nxt = MOVE;
			MOVE:
				if (!take)
					state_nxt = FINISH;  // Count done or section ran dry.
			FINISH: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	//////////////////////////////
	// Control.
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state       <= IDLE;
			have_pend   <= 1'b0;
			job_section <= '0;
			dram_req    <= '0;
			dram_be     <= '0;
		end
		else
		begin
			state    <= state_nxt;
			dram_req <= '0;     // One cycle per command.
			dram_be  <= '0;
			if (state == LOAD)
			begin
				have_pend   <= 1'b0;
				job_section <= section;
			end
			if (take)
			begin
				if (!cur_addr[0])
					have_pend <= 1'b1;
				else
				begin
					have_pend <= 1'b0;
					dram_req  <= job_bank;
					dram_be   <= {have_pend, have_pend, 2'b11};
				end
			end
			if (flush)
			begin
				have_pend <= 1'b0;
				dram_req  <= job_bank;
				dram_be   <= 4'b1100;
			end
		end
	end

	//////////////////////////////
	// Job and data path.
	always_ff @(posedge CLK)
	begin
		if (state == LOAD)
		begin
			cur_addr <= start_addr;
			left     <= count;
			job_cnt  <= count;
			job_bank <= bank_sel;
		end
		if (take)
		begin
			cur_addr <= cur_addr + 1'b1;
			left     <= left - 1'b1;
			if (!cur_addr[0])
				pend_word <= buff.word;
			else
			begin
				dram_data <= {(have_pend ? pend_word : lsab_word_t'(0)), buff.word};
				dram_addr <= cur_addr & ~word_addr_t'(1);
			end
		end
		if (flush)
		begin
			dram_data <= {pend_word, lsab_word_t'(0)};
			dram_addr <= cur_addr & ~word_addr_t'(1);  // Pair base of the lone word.
		end
	end

endmodule

`default_nettype wire

// ==== mover/mover_status.sv ====
// Completion status block with sticky done, interrupt and last record.
`timescale 1ns/10ps
`default_nettype none

module mover_status
(
	input  wire                  CLK,
	input  wire                  RST,
	done_if.sink                 fin,
	input  wire                  clear_done,
	output logic                 done,
	output logic                 irq_flag,
	output logic                 abrupt,
	output mover_pkg::word_cnt_t sent,
	output mover_pkg::ancill_t   ancill,
	output logic                 irq
);
	assign irq = done;  // Interrupt follows the sticky done bit.

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			done     <= 1'b0;
			irq_flag <= 1'b0;
			abrupt   <= 1'b0;
			sent     <= '0;
		end
		else if (fin.done)
		begin
			done     <= 1'b1;   // A new record wins over a clear.
			irq_flag <= fin.irq_flag;
			abrupt   <= fin.abrupt;
			sent     <= fin.sent;
		end
		else if (clear_done)
			done <= 1'b0;
	end

	// Tag of the last transfer.
	always_ff @(posedge CLK)
	begin
		if (fin.done)
			ancill <= fin.ancill;
	end

endmodule

`default_nettype wire

// ==== logic/block_mover_top.sv ====
// Block mover top level joining the LSAB, registers, engine and status.
`timescale 1ns/10ps
`default_nettype none

`include "mover_defs.svh"

module block_mover_top
(
	input  wire                        CLK,
	input  wire                        RST,
	input  wire [`MOVER_APB_AW-1:0]    paddr,
	input  wire                        psel,
	input  wire                        penable,
	input  wire                        pwrite,
	input  wire [`MOVER_APB_DW-1:0]    pwdata,
	output logic [`MOVER_APB_DW-1:0]   prdata,
	output logic                       pready,
	output logic                       pslverr,
	input  wire                        lsab_wr,
	input  wire mover_pkg::section_t   lsab_wr_section,
	input  wire mover_pkg::lsab_word_t lsab_wr_data,
	input  wire                        lsab_mark,
	input  wire                        lsab_mark_int,
	input  wire mover_pkg::ancill_t    lsab_mark_ancill,
	output logic                       lsab_full,
	output mover_pkg::bank_sel_t       dram_req,
	output mover_pkg::word_addr_t      dram_addr,
	output mover_pkg::dram_word_t      dram_data,
	output mover_pkg::byte_en_t        dram_be,
	output logic                       irq
);
	import mover_pkg::*;

	word_addr_t start_addr;
	word_cnt_t  count;
	section_t   section;
	bank_sel_t  bank_sel;
	logic       issue;
	logic       busy;
	logic       done;
	logic       irq_flag;
	logic       abrupt;
	word_cnt_t  sent;
	ancill_t    ancill;
	logic       clear_done;

	lsab_if lsab_bus ();
	done_if done_bus ();

	lsab_sections u_lsab (.CLK, .RST, .wr(lsab_wr), .wr_section(lsab_wr_section),
		.wr_data(lsab_wr_data), .mark(lsab_mark), .mark_int(lsab_mark_int),
		.mark_ancill(lsab_mark_ancill), .full(lsab_full), .rd_port(lsab_bus));

	mover_regs u_regs (.CLK, .RST, .paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr, .start_addr, .count, .section, .bank_sel,
		.issue, .busy, .done, .irq_flag, .abrupt, .sent, .ancill, .clear_done);

	mover_engine u_engine (.CLK, .RST, .start_addr, .count, .section, .bank_sel,
		.issue, .busy, .buff(lsab_bus), .fin(done_bus), .dram_req, .dram_addr,
		.dram_data, .dram_be);

	mover_status u_status (.CLK, .RST, .fin(done_bus), .clear_done, .done,
		.irq_flag, .abrupt, .sent, .ancill, .irq);

endmodule

`default_nettype wire

// ==== verif/tb_block_mover.sv ====
// Testbench with clock, APB tasks, LSAB loader, DRAM monitor and reference model.
`timescale 1ns/10ps
`default_nettype none

`include "mover_defs.svh"

module tb_block_mover;
	import mover_pkg::*;

	localparam int          MAX_CASES = 32;
	localparam logic [31:0] SEED      = 32'h7529_7f7a;

	logic        CLK;
	logic        RST;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        lsab_wr;
	section_t    lsab_wr_section;
	lsab_word_t  lsab_wr_data;
	logic        lsab_mark;
	logic        lsab_mark_int;
	ancill_t     lsab_mark_ancill;
	logic        lsab_full;
	bank_sel_t   dram_req;
	word_addr_t  dram_addr;
	dram_word_t  dram_data;
	byte_en_t    dram_be;
	logic        irq;

	// Case table from the data file.
	logic [8*24-1:0] case_name [MAX_CASES];
	section_t        c_section [MAX_CASES];
	bank_sel_t       c_bank [MAX_CASES];
	word_addr_t      c_start [MAX_CASES];
	word_cnt_t       c_count [MAX_CASES];
	int              c_preload [MAX_CASES];
	logic            c_int [MAX_CASES];
	ancill_t         c_ancill [MAX_CASES];
	word_cnt_t       c_sent [MAX_CASES];
	logic            c_abrupt [MAX_CASES];
	int              n_cases;

	// Expected section contents.
	lsab_word_t model_mem [4][`LSAB_DEPTH];
	int         model_head [4];
	int         model_fill [4];

	word_addr_t  exp_addr [$];   // Expected DRAM commands, in order.
	dram_word_t  exp_data [$];
	byte_en_t    exp_be [$];
	bank_sel_t   exp_req [$];
	dram_word_t  mon_mask;
	logic [31:0] lfsr_state;
	string       cur_name;
	int          cycle_count;
	int          cycle_limit;

	block_mover_top i_dut
	(
		.CLK(CLK), .RST(RST), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .lsab_wr(lsab_wr), .lsab_wr_section(lsab_wr_section),
		.lsab_wr_data(lsab_wr_data), .lsab_mark(lsab_mark), .lsab_mark_int(lsab_mark_int),
		.lsab_mark_ancill(lsab_mark_ancill), .lsab_full(lsab_full), .dram_req(dram_req),
		.dram_addr(dram_addr), .dram_data(dram_data), .dram_be(dram_be), .irq(irq)
	);

	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			fail_run($sformatf("[FAIL] %s: expected %h, actual %h", what, expected, actual));
	endtask

	// Galois LFSR, right shifting.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_word(output lsab_word_t w);
		w = '0;
		for (int i = 0; i < 16; i++)
		begin
			w          = {w[14:0], lfsr_state[0]};  // One step per bit.
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic dram_word_t lane_mask(input byte_en_t be);
		dram_word_t m;
		for (int i = 0; i < 4; i++)
			m[8*i +: 8] = {8{be[i]}};
		return m;
	endfunction

	//////////////////////////////
	// APB master.
	task automatic apb_access(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge CLK);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge CLK);
		#2;
		penable = 1'b1;
		@(negedge CLK);   // Access phase, outputs settled.
		rdata = prdata;
		err   = pslverr;
		check_value($sformatf("%s pready", cur_name), 1, pready);
		@(posedge CLK);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] rdata;
		logic        err;
		apb_access(1'b1, addr, wdata, rdata, err);
		check_value($sformatf("%s pslverr on write to %h", cur_name, addr), 0, err);
	endtask

	task automatic reg_read(input logic [7:0] addr, output logic [31:0] rdata);
		logic err;
		apb_access(1'b0, addr, 32'h0, rdata, err);
		check_value($sformatf("%s pslverr on read of %h", cur_name, addr), 0, err);
	endtask

	//////////////////////////////
	// LSAB loader and reference model.
	task automatic load_section(input section_t sec, input int words, input logic flag,
		input ancill_t tag);
		lsab_word_t w;
		int         slot;
		for (int i = 0; i < words; i++)
		begin
			random_word(w);
			@(posedge CLK);
			#2;
			lsab_wr         = 1'b1;
			lsab_wr_section = sec;
			lsab_wr_data    = w;
			@(negedge CLK);   // Full reflects the words written before this one.
			check_value($sformatf("%s lsab_full", cur_name),
				(model_fill[sec] >= `LSAB_DEPTH), lsab_full);
			if (model_fill[sec] < `LSAB_DEPTH)   // A full section drops the word.
			begin
				slot                 = (model_head[sec] + model_fill[sec]) % `LSAB_DEPTH;
				model_mem[sec][slot] = w;
				model_fill[sec]++;
			end
		end
		@(posedge CLK);
		#2;
		lsab_wr          = 1'b0;
		lsab_mark        = 1'b1;
		lsab_wr_section  = sec;
		lsab_mark_int    = flag;
		lsab_mark_ancill = tag;
		@(posedge CLK);
		#2;
		lsab_mark = 1'b0;
	endtask

	task automatic expect_commands(input section_t sec, input bank_sel_t bank,
		input word_addr_t start, input word_cnt_t count);
		int         n;
		word_addr_t a;
		lsab_word_t w;
		lsab_word_t pend;
		logic       have;
		n    = (count < model_fill[sec]) ? count : model_fill[sec];
		have = 1'b0;
		pend = '0;
		a    = start;
		for (int i = 0; i < n; i++)
		begin
			a               = start + word_addr_t'(i);
			w               = model_mem[sec][model_head[sec]];
			model_head[sec] = (model_head[sec] + 1) % `LSAB_DEPTH;
			model_fill[sec]--;
			if (!a[0])
			begin
				pend = w;
				have = 1'b1;
			end
			else
			begin
				exp_req.push_back(bank);
				exp_addr.push_back({a[`MOVER_ADDR_W-1:1], 1'b0});
				exp_data.push_back({pend, w});
				exp_be.push_back(have ? 4'b1111 : 4'b0011);
				have = 1'b0;
			end
		end
		if (have)   // Lone even word at the end.
		begin
			exp_req.push_back(bank);
			exp_addr.push_back({a[`MOVER_ADDR_W-1:1], 1'b0});
			exp_data.push_back({pend, 16'h0});
			exp_be.push_back(4'b1100);
		end
	endtask

	//////////////////////////////
	// DRAM monitor.
	always @(negedge CLK)
	begin
		if (RST === 1'b1 && dram_req !== 2'b00)
		begin
			if (exp_req.size() == 0)
				fail_run($sformatf("%s: DRAM command at address %h was not expected.",
					cur_name, dram_addr));
			else
			begin
				mon_mask = lane_mask(exp_be[0]);
				check_value($sformatf("%s dram_req", cur_name), exp_req[0], dram_req);
				check_value($sformatf("%s dram_be", cur_name), exp_be[0], dram_be);
				check_value($sformatf("%s dram_addr", cur_name), exp_addr[0], dram_addr);
				check_value($sformatf("%s dram_data", cur_name), exp_data[0] & mon_mask,
					dram_data & mon_mask);
				void'(exp_req.pop_front());
				void'(exp_be.pop_front());
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	always @(posedge CLK)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
			fail_run($sformatf("Timeout: the run took more than %0d cycles.", cycle_limit));
	end

	task automatic read_cases();
		int              fd;
		int              rc;
		int              total;
		logic [8*128-1:0] line;
		logic [8*24-1:0] name;
		int              sec, bank, start, cnt, pre, flag, anc, sent, abr;
		n_cases = 0;
		total   = 0;
		fd      = $fopen("verif/mover_cases.txt", "r");
		if (fd == 0)
			fail_run("Cannot open the case file verif/mover_cases.txt.");
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				rc = $sscanf(line, "%s %d %d %h %d %d %d %h %d %d", name, sec, bank, start,
					cnt, pre, flag, anc, sent, abr);
				if (rc == 10 && n_cases < MAX_CASES)   // Comment lines match fewer fields.
				begin
					case_name[n_cases] = name;
					c_section[n_cases] = sec;
					c_bank[n_cases]    = bank;
					c_start[n_cases]   = start;
					c_count[n_cases]   = cnt;
					c_preload[n_cases] = pre;
					c_int[n_cases]     = flag;
					c_ancill[n_cases]  = anc;
					c_sent[n_cases]    = sent;
					c_abrupt[n_cases]  = abr;
					total              = total + cnt;
					n_cases++;
				end
			end
			$fclose(fd);
			if (n_cases == 0)
				fail_run("The case file holds no test case.");
			else
				cycle_limit = (total + 40 * n_cases) * n_cases;
		end
	endtask

	task automatic run_case(input int k);
		logic [31:0] rdata;
		logic        err;
		logic [31:0] status_exp;
		cur_name = $sformatf("%0s", case_name[k]);
		load_section(c_section[k], c_preload[k], c_int[k], c_ancill[k]);
		reg_write(`REG_ADDR, c_start[k]);
		reg_write(`REG_COUNT, c_count[k]);
		expect_commands(c_section[k], c_bank[k], c_start[k], c_count[k]);
		reg_write(`REG_CTRL, {27'h0, 1'b1, c_bank[k], c_section[k]});
		// Second issue lands while the engine is busy.
		apb_access(1'b1, `REG_CTRL, {27'h0, 1'b1, ~c_bank[k], ~c_section[k]}, rdata, err);
		check_value($sformatf("%s pslverr on issue while busy", cur_name), 1, err);
		do
			@(negedge CLK);
		while (irq !== 1'b1);
		@(posedge CLK);
		check_value($sformatf("%s DRAM commands missing", cur_name), 0, exp_req.size());
		reg_read(`REG_CTRL, rdata);
		check_value($sformatf("%s CTRL", cur_name), {28'h0, c_bank[k], c_section[k]}, rdata);
		status_exp        = 32'h2;   // Done, not working.
		status_exp[2]     = c_int[k];
		status_exp[3]     = c_abrupt[k];
		status_exp[13:8]  = c_sent[k];
		reg_read(`REG_STATUS, rdata);
		check_value($sformatf("%s STATUS", cur_name), status_exp, rdata);
		reg_read(`REG_ANCILL, rdata);
		check_value($sformatf("%s ANCILL", cur_name), c_ancill[k], rdata);
		reg_write(`REG_STATUS, 32'h2);
		@(posedge CLK);
		@(negedge CLK);
		check_value($sformatf("%s irq after clear", cur_name), 0, irq);
		reg_read(`REG_STATUS, rdata);
		check_value($sformatf("%s done after clear", cur_name), 0, rdata[1]);
	endtask

	//////////////////////////////
	// Main sequence.
	initial
	begin
		logic [31:0] rdata;
		logic        err;
		RST              = 1'b0;
		paddr            = '0;
		psel             = 1'b0;
		penable          = 1'b0;
		pwrite           = 1'b0;
		pwdata           = '0;
		lsab_wr          = 1'b0;
		lsab_wr_section  = '0;
		lsab_wr_data     = '0;
		lsab_mark        = 1'b0;
		lsab_mark_int    = 1'b0;
		lsab_mark_ancill = '0;
		lfsr_state       = SEED;
		cycle_count      = 0;
		cycle_limit      = 0;
		cur_name         = "reset";
		for (int s = 0; s < 4; s++)
		begin
			model_head[s] = 0;
			model_fill[s] = 0;
		end
		read_cases();
		repeat (3) @(posedge CLK);
		#2;
		RST = 1'b1;

		@(negedge CLK);
		check_value("reset dram_req", 0, dram_req);
		check_value("reset dram_be", 0, dram_be);
		check_value("reset irq", 0, irq);
		reg_read(`REG_STATUS, rdata);
		check_value("reset STATUS", 0, rdata);

		cur_name = "unmapped";
		apb_access(1'b0, 8'h14, 32'h0, rdata, err);
		check_value("unmapped read pslverr", 1, err);
		apb_access(1'b1, 8'h20, 32'h1f, rdata, err);
		check_value("unmapped write pslverr", 1, err);

		for (int k = 0; k < n_cases; k++)
			run_case(k);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/mover_pkg.sv
common/lsab_if.sv
common/done_if.sv
lsab/lsab_sections.sv
mover/mover_regs.sv
mover/mover_engine.sv
mover/mover_status.sv
logic/block_mover_top.sv
verif/tb_block_mover.sv

// ==== verif/mover_cases.txt ====
# name section bank start count preload int ancill sent abrupt
# start and ancill are hex, the other columns decimal
even_full      0 1 010 8  8  1 1abcdef 8  0
odd_tail       1 2 023 6  6  0 0000155 6  0
short_abrupt   2 3 040 10 5  1 0f0f0f0 5  1
keep_rest      3 1 100 4  10 0 1234567 4  0
other_section  0 2 201 3  3  1 0000001 3  0
drain_rest     3 3 300 6  0  1 1fffffe 6  0
empty_section  1 1 055 4  0  0 0aaaaaa 0  1
long_odd       2 2 7ff 33 33 1 1555555 33 0
max_count      0 1 400 63 63 0 0c0ffee 63 0
refill_over    1 3 0fe 63 70 1 0123456 63 0
